// ==== source/vend_defines.svh ====
// Vending machine widths, coin values, row prices and credit limit
`ifndef VEND_DEFINES_SVH
`define VEND_DEFINES_SVH

// Bus widths
`define CREDIT_W        10          // Cents, up to 999
`define COIN_W          3
`define ITEM_W          5

// Button matrix
`define NUM_ROWS        4           // Rows A to D
`define NUM_COLS        5           // Columns 1 to 5

// Coin values in cents for coin codes 1 to 6
`define COIN_VAL_1      1
`define COIN_VAL_2      5
`define COIN_VAL_3      10
`define COIN_VAL_4      25
`define COIN_VAL_5      50
`define COIN_VAL_6      100

// Row prices in cents
`define PRICE_A         100
`define PRICE_B         125
`define PRICE_C         150
`define PRICE_D         175

`define CREDIT_LIMIT    999         // Coins past this are refused

`endif

// ==== source/vend_pkg.sv ====
// Shared types and coin value lookup for the vending machine controller
`include "vend_defines.svh"
`default_nettype none

package vend_pkg;

    typedef logic [`CREDIT_W-1:0] credit_t;     // Amount in cents
    typedef logic [`COIN_W-1:0]   coin_t;       // 0 none, 1 to 6 coins, 7 invalid
    typedef logic [`ITEM_W-1:0]   item_t;       // 0 none, 1 to 20 items

    typedef enum logic [1:0] {
        ST_IDLE,                                // Taking coins and selections
        ST_VEND,                                // Waiting for the food sensor
        ST_CHANGE                               // Paying out the remainder
    } vend_state_t;

    // Cent value of a coin code, zero for no coin and the invalid code
    function automatic credit_t coin_value(input coin_t code);
        credit_t value;
        case (code)
            coin_t'(1): value = credit_t'(`COIN_VAL_1);
            coin_t'(2): value = credit_t'(`COIN_VAL_2);
            coin_t'(3): value = credit_t'(`COIN_VAL_3);
            coin_t'(4): value = credit_t'(`COIN_VAL_4);
            coin_t'(5): value = credit_t'(`COIN_VAL_5);
            coin_t'(6): value = credit_t'(`COIN_VAL_6);
            default:    value = '0;
        endcase
        return value;
    endfunction

endpackage

`default_nettype wire

// ==== source/selection_decoder.sv ====
// Selection decoder that masks unaffordable rows and forms item code and price
`include "vend_defines.svh"
`default_nettype none

module selection_decoder import vend_pkg::*; (
    input  credit_t              credit,
    input  logic [`NUM_ROWS-1:0] row_buttons,
    input  logic [`NUM_COLS-1:0] col_buttons,
    output logic                 sel_valid,
    output item_t                sel_item,
    output credit_t              sel_price
);

    localparam credit_t ROW_PRICE [`NUM_ROWS] = '{
        credit_t'(`PRICE_A),
        credit_t'(`PRICE_B),
        credit_t'(`PRICE_C),
        credit_t'(`PRICE_D)
    };

    logic [`NUM_ROWS-1:0] affordable;
    logic [`NUM_ROWS-1:0] row_mask;
    logic [2:0]           row_idx;
    logic [2:0]           col_idx;

    // Index of the lowest set bit, zero when none is set
    function automatic logic [2:0] lowest_set(input logic [`NUM_COLS-1:0] bits);
        logic [2:0] idx;
        idx = '0;
        for (int i = `NUM_COLS - 1; i >= 0; i--) begin
            if (bits[i]) begin
                idx = 3'(i);
            end
        end
        return idx;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Price gating
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        for (int r = 0; r < `NUM_ROWS; r++) begin
            affordable[r] = (credit >= ROW_PRICE[r]);
        end
    end

    assign row_mask = row_buttons & affordable;     // Only rows the credit covers

    //////////////////////////////////////////////////////////////////////
    // Priority encode and item code
    //////////////////////////////////////////////////////////////////////

    assign row_idx = lowest_set({{(`NUM_COLS - `NUM_ROWS){1'b0}}, row_mask});
    assign col_idx = lowest_set(col_buttons);

    assign sel_valid = (|row_mask) && (|col_buttons);

    always_comb begin
        if (sel_valid) begin
            sel_item  = item_t'(int'(row_idx) * `NUM_COLS + int'(col_idx) + 1);
            sel_price = ROW_PRICE[row_idx[1:0]];
        end else begin
            sel_item  = '0;                         // No item
            sel_price = '0;
        end
    end

endmodule

`default_nettype wire

// ==== source/credit_counter.sv ====
// Credit register that adds coins, charges the row price and pays out change
`include "vend_defines.svh"
`default_nettype none

module credit_counter import vend_pkg::*; (
    input  logic    clock,
    input  logic    reset,
    input  coin_t   coin_inserted,
    input  logic    accept_coins,
    input  logic    charge,
    input  credit_t sel_price,
    input  credit_t payout_value,
    output credit_t credit
);

    localparam int unsigned SUM_W = `CREDIT_W + 1;  // Room for one carry

    credit_t          coin_val;
    logic [SUM_W-1:0] with_coin;
    logic             coin_ok;
    credit_t          price_due;
    credit_t          credit_next;

    //////////////////////////////////////////////////////////////////////
    // Next credit
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        coin_val  = coin_value(coin_inserted);
        with_coin = {1'b0, credit} + {1'b0, coin_val};

        // Refuse no coin, invalid code and anything over the limit
        coin_ok = accept_coins && (coin_val != '0)
                  && (with_coin <= SUM_W'(`CREDIT_LIMIT));

        price_due = charge ? sel_price : '0;

        credit_next = (coin_ok ? with_coin[`CREDIT_W-1:0] : credit)
                      - price_due
                      - payout_value;               // Zero outside payout
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            credit <= '0;
        end else begin
            credit <= credit_next;
        end
    end

endmodule

`default_nettype wire

// ==== source/change_dispenser.sv ====
// Greedy change picker that returns one coin per cycle, largest first
`default_nettype none

module change_dispenser import vend_pkg::*; (
    input  logic    clock,
    input  logic    reset,
    input  logic    pay_enable,
    input  credit_t credit,
    output coin_t   coin_to_return,
    output credit_t payout_value
);

    localparam int NUM_COINS = 6;                   // Codes 1 to 6

    coin_t next_coin;

    //////////////////////////////////////////////////////////////////////
    // Coin choice
    //////////////////////////////////////////////////////////////////////

    // Values rise with the code, so the last fit is the largest
    always_comb begin
        next_coin = '0;
        if (pay_enable) begin
            for (int c = 1; c <= NUM_COINS; c++) begin
                if (coin_value(coin_t'(c)) <= credit) begin
                    next_coin = coin_t'(c);
                end
            end
        end
    end

    assign payout_value = coin_value(next_coin);    // Taken off credit this edge

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            coin_to_return <= '0;
        end else begin
            coin_to_return <= next_coin;            // Zero when nothing is paid
        end
    end

endmodule

`default_nettype wire

// ==== source/vend_fsm.sv ====
// Controller state machine for idle, vend and change payout
`default_nettype none

module vend_fsm import vend_pkg::*; (
    input  logic    clock,
    input  logic    reset,
    input  credit_t credit,
    input  logic    sel_valid,
    input  item_t   sel_item,
    input  logic    food_dispensed,
    output logic    accept_coins,
    output logic    charge,
    output logic    pay_enable,
    output item_t   food_selection
);

    vend_state_t state;
    vend_state_t state_next;
    logic        vend_done;
    logic        change_done;

    //////////////////////////////////////////////////////////////////////
    // Control outputs
    //////////////////////////////////////////////////////////////////////

    assign accept_coins = (state == ST_IDLE);
    assign charge       = sel_valid && (state == ST_IDLE);
    assign pay_enable   = (state == ST_CHANGE);

    assign vend_done   = (state == ST_VEND) && food_dispensed;
    assign change_done = (state == ST_CHANGE) && (credit == '0);

    //////////////////////////////////////////////////////////////////////
    // State transitions
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        state_next = state;
        case (state)
            ST_IDLE: begin
                if (charge) begin
                    state_next = ST_VEND;
                end
            end
            ST_VEND: begin
                if (vend_done) begin
                    state_next = ST_CHANGE;         // Food has dropped
                end
            end
            ST_CHANGE: begin
                if (change_done) begin
                    state_next = ST_IDLE;
                end
            end
            default: begin
                state_next = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= ST_IDLE;
        end else begin
            state <= state_next;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Item code register
    //////////////////////////////////////////////////////////////////////

    // Holds the chosen item for the whole vend
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            food_selection <= '0;
        end else if (charge) begin
            food_selection <= sel_item;             // Entering vend
        end else if (vend_done) begin
            food_selection <= '0;                   // Leaving vend
        end
    end

endmodule

`default_nettype wire

// ==== source/vending_machine.sv ====
// Vending machine controller top level joining FSM, decoder, counter and dispenser
`include "vend_defines.svh"
`default_nettype none

module vending_machine import vend_pkg::*; (
    input  logic                 clock,
    input  logic                 reset,
    input  coin_t                coin_inserted,
    input  logic [`NUM_ROWS-1:0] row_buttons,     // Bit 0 is row A
    input  logic [`NUM_COLS-1:0] col_buttons,     // Bit 0 is column 1
    input  logic                 food_dispensed,
    output credit_t              credit_display,
    output item_t                food_selection,
    output coin_t                coin_to_return
);

    credit_t credit;
    logic    sel_valid;
    item_t   sel_item;
    credit_t sel_price;
    logic    accept_coins;
    logic    charge;
    logic    pay_enable;
    credit_t payout_value;

    assign credit_display = credit;                 // Live credit

    //////////////////////////////////////////////////////////////////////
    // Control
    //////////////////////////////////////////////////////////////////////

    vend_fsm u_vend_fsm (
        .clock          (clock),
        .reset          (reset),
        .credit         (credit),
        .sel_valid      (sel_valid),
        .sel_item       (sel_item),
        .food_dispensed (food_dispensed),
        .accept_coins   (accept_coins),
        .charge         (charge),
        .pay_enable     (pay_enable),
        .food_selection (food_selection)
    );

    selection_decoder u_selection_decoder (
        .credit      (credit),
        .row_buttons (row_buttons),
        .col_buttons (col_buttons),
        .sel_valid   (sel_valid),
        .sel_item    (sel_item),
        .sel_price   (sel_price)
    );

    //////////////////////////////////////////////////////////////////////
    // Money path
    //////////////////////////////////////////////////////////////////////

    credit_counter u_credit_counter (
        .clock         (clock),
        .reset         (reset),
        .coin_inserted (coin_inserted),
        .accept_coins  (accept_coins),
        .charge        (charge),
        .sel_price     (sel_price),
        .payout_value  (payout_value),
        .credit        (credit)
    );

    change_dispenser u_change_dispenser (
        .clock          (clock),
        .reset          (reset),
        .pay_enable     (pay_enable),
        .credit         (credit),
        .coin_to_return (coin_to_return),
        .payout_value   (payout_value)
    );

endmodule

`default_nettype wire

// ==== tb/vending_machine_tb.sv ====
// Testbench for the vending machine controller driven from a purchase table
`include "vend_defines.svh"
`default_nettype none

module vending_machine_tb import vend_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 8;
    localparam int NUM_TESTS    = 8;
    localparam int CYCLE_BUDGET = 100;          // Cycles allowed per table row
    localparam int MAX_PAYOUT   = 32;
    localparam int WATCHDOG_NS  = NUM_TESTS * CYCLE_BUDGET * CLK_PERIOD;

    logic                 clock;
    logic                 reset;
    coin_t                coin_inserted;
    logic [`NUM_ROWS-1:0] row_buttons;
    logic [`NUM_COLS-1:0] col_buttons;
    logic                 food_dispensed;
    credit_t              credit_display;
    item_t                food_selection;
    coin_t                coin_to_return;

    coin_t                tbl_coins [NUM_TESTS][6];
    logic [`NUM_ROWS-1:0] tbl_rows  [NUM_TESTS];
    logic [`NUM_COLS-1:0] tbl_cols  [NUM_TESTS];
    int                   tbl_delay [NUM_TESTS];   // Upper bound on sensor delay
    int                   tbl_count;

    logic [31:0] lfsr;
    credit_t     exp_credit;
    item_t       exp_item;
    coin_t       exp_coins [$];

    vending_machine u_vending_machine (
        .clock          (clock),
        .reset          (reset),
        .coin_inserted  (coin_inserted),
        .row_buttons    (row_buttons),
        .col_buttons    (col_buttons),
        .food_dispensed (food_dispensed),
        .credit_display (credit_display),
        .food_selection (food_selection),
        .coin_to_return (coin_to_return)
    );

    always #(CLK_PERIOD / 2) clock = ~clock;

    //////////////////////////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////////////////////////

    function automatic credit_t cents_of(input coin_t code);
        case (code)
            3'd1:    return credit_t'(`COIN_VAL_1);
            3'd2:    return credit_t'(`COIN_VAL_2);
            3'd3:    return credit_t'(`COIN_VAL_3);
            3'd4:    return credit_t'(`COIN_VAL_4);
            3'd5:    return credit_t'(`COIN_VAL_5);
            3'd6:    return credit_t'(`COIN_VAL_6);
            default: return '0;
        endcase
    endfunction

    function automatic credit_t row_price(input int r);
        case (r)
            0:       return credit_t'(`PRICE_A);
            1:       return credit_t'(`PRICE_B);
            2:       return credit_t'(`PRICE_C);
            default: return credit_t'(`PRICE_D);
        endcase
    endfunction

    // Lowest pressed row the credit covers and lowest pressed column
    task automatic model_select(input logic [`NUM_ROWS-1:0] rows,
                                input logic [`NUM_COLS-1:0] cols);
        int r_sel;
        int c_sel;
        r_sel = -1;
        c_sel = -1;
        for (int r = `NUM_ROWS - 1; r >= 0; r--) begin
            if (rows[r] && exp_credit >= row_price(r)) begin
                r_sel = r;
            end
        end
        for (int c = `NUM_COLS - 1; c >= 0; c--) begin
            if (cols[c]) begin
                c_sel = c;
            end
        end
        if (r_sel >= 0 && c_sel >= 0) begin
            exp_item   = item_t'(r_sel * `NUM_COLS + c_sel + 1);
            exp_credit = exp_credit - row_price(r_sel);
        end else begin
            exp_item = '0;
        end
    endtask

    // Greedy change list with the largest coin first
    task automatic model_change();
        int rest;
        rest = int'(exp_credit);
        exp_coins.delete();
        for (int c = 6; c >= 1; c--) begin
            while (rest >= int'(cents_of(coin_t'(c)))) begin
                exp_coins.push_back(coin_t'(c));
                rest -= int'(cents_of(coin_t'(c)));
            end
        end
    endtask

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // Taps 32 22 2 1
    endfunction

    task automatic draw_bits(input int n, output int val);
        val = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            val  = (val << 1) | int'(lfsr[0]);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Compare tasks
    //////////////////////////////////////////////////////////////////////

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "Simulation stopped on error");
    endtask

    task automatic check_credit(input credit_t got, input credit_t exp, input string what);
        if (got !== exp) begin
            stop_run($sformatf("[FAIL] time %0d ns: %s credit %0d, expected %0d",
                               $time, what, got, exp));
        end
    endtask

    task automatic check_item(input item_t got, input item_t exp, input string what);
        if (got !== exp) begin
            stop_run($sformatf("[FAIL] time %0d ns: %s item %0d, expected %0d",
                               $time, what, got, exp));
        end
    endtask

    task automatic check_coin(input coin_t got, input coin_t exp, input string what);
        if (got !== exp) begin
            stop_run($sformatf("[FAIL] time %0d ns: %s coin %0d, expected %0d",
                               $time, what, got, exp));
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////////////////////////

    task automatic add_row(input coin_t c0, c1, c2, c3, c4, c5,
                           input logic [`NUM_ROWS-1:0] rows,
                           input logic [`NUM_COLS-1:0] cols, input int limit);
        tbl_coins[tbl_count] = '{c0, c1, c2, c3, c4, c5};
        tbl_rows[tbl_count]  = rows;
        tbl_cols[tbl_count]  = cols;
        tbl_delay[tbl_count] = limit;
        tbl_count++;
    endtask

    task automatic insert_coin(input coin_t code);
        @(posedge clock);
        coin_inserted <= code;
        @(posedge clock);
        coin_inserted <= '0;
        if (cents_of(code) != '0 && int'(exp_credit) + int'(cents_of(code)) <= `CREDIT_LIMIT) begin
            exp_credit = exp_credit + cents_of(code);
        end
        @(negedge clock);
        check_credit(credit_display, exp_credit, $sformatf("after coin code %0d", code));
    endtask

    task automatic press_buttons(input logic [`NUM_ROWS-1:0] rows,
                                 input logic [`NUM_COLS-1:0] cols);
        @(posedge clock);
        row_buttons <= rows;
        col_buttons <= cols;
        @(posedge clock);
        row_buttons <= '0;
        col_buttons <= '0;
        model_select(rows, cols);
        @(negedge clock);
        check_item(food_selection, exp_item, "after button press");
        check_credit(credit_display, exp_credit, "after button press");
        check_coin(coin_to_return, '0, "after button press");
    endtask

    // Holds the sensor low for a random time while a coin is offered
    task automatic vend_item(input int limit);
        int wait_cycles;
        draw_bits(3, wait_cycles);
        if (wait_cycles > limit) begin
            wait_cycles = limit;
        end
        repeat (wait_cycles) begin
            @(posedge clock);
            coin_inserted <= 3'd6;
            @(negedge clock);
            check_item(food_selection, exp_item, "during vend");
            check_credit(credit_display, exp_credit, "during vend");
            check_coin(coin_to_return, '0, "during vend");
        end
        @(posedge clock);
        coin_inserted  <= '0;
        food_dispensed <= 1'b1;
        @(posedge clock);
        food_dispensed <= 1'b0;
        @(negedge clock);
        check_item(food_selection, '0, "after food sensor");
        check_credit(credit_display, exp_credit, "after food sensor");
    endtask

    task automatic collect_change();
        int paid;
        int cycles;
        paid   = 0;
        cycles = 0;
        model_change();
        do begin
            @(negedge clock);
            cycles++;
            if (coin_to_return != '0) begin
                if (paid >= exp_coins.size()) begin
                    stop_run("More change coins came out than the remainder needs");
                end
                check_coin(coin_to_return, exp_coins[paid], "change payout");
                exp_credit = exp_credit - cents_of(exp_coins[paid]);
                check_credit(credit_display, exp_credit, "change payout");
                paid++;
            end
            if (cycles > MAX_PAYOUT) begin
                stop_run("Change payout did not finish within the allowed number of cycles");
            end
        end while (coin_to_return != '0);
        if (paid != exp_coins.size()) begin
            stop_run($sformatf("Only %0d of %0d change coins came out", paid, exp_coins.size()));
        end
        check_credit(credit_display, '0, "after change payout");
    endtask

    task automatic reset_during_vend();
        insert_coin(3'd6);
        insert_coin(3'd6);
        press_buttons(4'b0001, 5'b00001);
        @(posedge clock);
        reset <= 1'b1;
        @(negedge clock);
        exp_credit = '0;
        exp_item   = '0;
        check_credit(credit_display, exp_credit, "reset during vend");
        check_item(food_selection, exp_item, "reset during vend");
        check_coin(coin_to_return, '0, "reset during vend");
        repeat (2) @(posedge clock);
        reset <= 1'b0;
        insert_coin(3'd3);                      // Machine takes coins again
    endtask

    //////////////////////////////////////////////////////////////////////
    // Main sequence and watchdog
    //////////////////////////////////////////////////////////////////////

    initial begin
        clock          = 1'b0;
        reset          = 1'b1;
        coin_inserted  = '0;
        row_buttons    = '0;
        col_buttons    = '0;
        food_dispensed = 1'b0;
        lfsr           = 32'hede0;
        exp_credit     = '0;
        exp_item       = '0;
        tbl_count      = 0;
        add_row(3'd6, 3'd0, 3'd0, 3'd0, 3'd0, 3'd0, 4'b0001, 5'b00001, 7);   // Exact price
        add_row(3'd5, 3'd4, 3'd3, 3'd2, 3'd1, 3'd7, 4'b0001, 5'b00001, 3);   // Too little
        add_row(3'd4, 3'd0, 3'd0, 3'd0, 3'd0, 3'd0, 4'b0011, 5'b00110, 5);
        add_row(3'd6, 3'd6, 3'd6, 3'd6, 3'd6, 3'd6, 4'b1000, 5'b10000, 7);
        add_row(3'd6, 3'd6, 3'd6, 3'd6, 3'd6, 3'd6, 4'b0000, 5'b00000, 2);   // No buttons
        add_row(3'd6, 3'd6, 3'd6, 3'd6, 3'd5, 3'd4, 4'b1010, 5'b10100, 7);   // Hits the limit
        add_row(3'd6, 3'd5, 3'd0, 3'd0, 3'd0, 3'd0, 4'b0100, 5'b01000, 1);
        add_row(3'd6, 3'd4, 3'd4, 3'd1, 3'd1, 3'd1, 4'b1111, 5'b11111, 6);
        repeat (RESET_CYCLES) @(posedge clock);
        reset <= 1'b0;
        @(negedge clock);
        check_credit(credit_display, '0, "after reset");
        check_item(food_selection, '0, "after reset");
        check_coin(coin_to_return, '0, "after reset");
        for (int t = 0; t < tbl_count; t++) begin
            for (int i = 0; i < 6; i++) begin
                if (tbl_coins[t][i] != '0) begin
                    insert_coin(tbl_coins[t][i]);
                end
            end
            press_buttons(tbl_rows[t], tbl_cols[t]);
            if (exp_item != '0) begin
                vend_item(tbl_delay[t]);
                collect_change();
            end
        end
        reset_during_vend();
        $display("TEST PASSED");
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        stop_run($sformatf("Watchdog expired after %0d ns before the tests finished",
                           WATCHDOG_NS));
    end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+source
source/vend_pkg.sv
source/selection_decoder.sv
source/credit_counter.sv
source/change_dispenser.sv
source/vend_fsm.sv
source/vending_machine.sv
tb/vending_machine_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the vending machine testbench with Verilator
set -e

cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG_FILE=sim.log
SIM_BIN=vending_machine_sim

verilator --binary --timing -j 0 \
    -f list.f \
    --top-module vending_machine_tb \
    -Mdir "$BUILD_DIR" \
    -o "$SIM_BIN"

"./$BUILD_DIR/$SIM_BIN" | tee "$LOG_FILE"

if grep -q "TEST PASSED" "$LOG_FILE"; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed, see $LOG_FILE"
    exit 1
fi
